// ==== tb/snes_cart_trace.txt ====
# op addr data mode, one access per line
# SR/SW take a SNES address, DR/DW/BR/BW an SRAM byte address; data is written or expected
DW 000000 a5 0
DW 000001 3c 0
SR 008000 a5 0
SR 008001 3c 0
SR 808000 a5 0
BW 010004 e7 1
SR 028004 e7 0
SW 038010 91 0
DR 018010 91 0
SW 838011 4e 0
DR 018011 4e 0
DR 018010 91 0
DW 000100 11 0
DW 000101 22 0
DW 000101 77 0
DR 000100 11 0
DR 000101 77 0
DW 000100 66 0
DR 000100 66 0
DR 000101 77 0
SR 000000 00 0
SR 7e8000 00 0
SR 7f9000 00 0
BR 018011 4e 1
BR 000100 66 0
DW 07ffff c3 0
SR 0fffff c3 0
SR 1fffff c3 0

// ==== src.f ====
+incdir+hw
hw/snes_cart_pkg.sv
hw/snes_addr_decode.sv
hw/sram_sequencer.sv
hw/cart_data_path.sv
hw/snes_cart_top.sv
tb/sram_model.sv
tb/tb_snes_cart_top.sv

// ==== Bender.yml ====
package:
  name: snes_cart

sources:
  - include_dirs:
      - hw
    files:
      - hw/snes_cart_pkg.sv
      - hw/snes_addr_decode.sv
      - hw/sram_sequencer.sv
      - hw/cart_data_path.sv
      - hw/snes_cart_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/sram_model.sv
      - tb/tb_snes_cart_top.sv

// ==== tb/tb_snes_cart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snes_cart_settings.svh"

module tb_snes_cart_top
   import snes_cart_pkg::*;
();

   // Strobe length per access covers sync, wait states and margin
   localparam int HOLD_CYC     = 2 + `SRAM_WAIT + 4;
   localparam int IDLE_TIMEOUT = 16;

   logic       CLK;
   logic       rst_n;
   snes_addr_t snes_addr;
   logic       snes_read;
   logic       snes_write;
   byte_t      snes_drv;
   logic       snes_drv_en;
   wire byte_t snes_data;
   sram_addr_t avr_addr;
   logic       avr_read;
   logic       avr_write;
   byte_t      avr_in_data;
   byte_t      avr_out_data;
   logic       avr_ena;
   logic       mode;
   sram_addr_t sram_addr;
   logic       sram_oe_n;
   logic       sram_we_n;
   wire sram_word_t sram_data;

   int    seed;
   int    mismatch_cnt;
   int    other_cnt;
   logic  abort;
   byte_t ref_mem [int];

   always #4 CLK = ~CLK;

   assign snes_data = snes_drv_en ? snes_drv : 8'hzz;

   snes_cart_top DUT (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .snes_addr    (snes_addr),
      .snes_read    (snes_read),
      .snes_write   (snes_write),
      .snes_data    (snes_data),
      .avr_addr     (avr_addr),
      .avr_read     (avr_read),
      .avr_write    (avr_write),
      .avr_in_data  (avr_in_data),
      .avr_out_data (avr_out_data),
      .avr_ena      (avr_ena),
      .mode         (mode),
      .sram_addr    (sram_addr),
      .sram_oe_n    (sram_oe_n),
      .sram_we_n    (sram_we_n),
      .sram_data    (sram_data)
   );

   sram_model u_sram (
      .addr (sram_addr),
      .oe_n (sram_oe_n),
      .we_n (sram_we_n),
      .data (sram_data)
   );

   //////////////////////////////
   // LoROM reference rules
   //////////////////////////////

   function automatic logic lorom_mapped(input snes_addr_t a);
      logic [7:0] bank;
      bank = a[23:16];
      return a[15] && (bank != 8'h7E) && (bank != 8'h7F);
   endfunction

   // Bank bit 7 is a mirror and each bank holds 32K of ROM
   function automatic int lorom_byte(input snes_addr_t a);
      int page;
      page = a[22:16];
      return (page * 32'h8000 + a[14:0]) % (1 << `SRAM_ADDR_W);
   endfunction

   //////////////////////////////
   // Reporting
   //////////////////////////////

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("error at %0t ns: %s", $time, msg);
      other_cnt++;
   endtask

   task automatic expect_ref(input int ba, input byte_t e);
      if (!ref_mem.exists(ba)) begin
         report_error("trace reads a byte that was never written");
      end else if (ref_mem[ba] !== e) begin
         report_error("trace value disagrees with the reference byte array");
      end
   endtask

   //////////////////////////////
   // Bus tasks
   //////////////////////////////

   task automatic wait_chip_idle();
      int i;
      i = 0;
      while (i < IDLE_TIMEOUT && !(sram_oe_n && sram_we_n)) begin
         @(negedge CLK);
         i++;
      end
      if (!(sram_oe_n && sram_we_n)) begin
         report_error("timed out waiting for the SRAM strobes to go idle");
         abort = 1'b1;
      end
   endtask

   task automatic snes_access(input logic is_write, input snes_addr_t a, input byte_t d,
                              output byte_t got, output logic seen);
      seen        = 1'b0;
      avr_ena     = 1'b1;
      snes_addr   = a;
      snes_drv    = d;
      snes_drv_en = is_write;
      @(negedge CLK);
      if (is_write) begin
         snes_write = 1'b0;
      end else begin
         snes_read = 1'b0;
      end
      for (int i = 0; i < HOLD_CYC; i++) begin
         @(negedge CLK);
         if (!sram_oe_n || !sram_we_n) begin
            // SRAM address on the first strobe cycle
            if (!seen) begin
               check("sram_addr", sram_addr, lorom_byte(a));
            end
            seen = 1'b1;
         end
      end
      got         = snes_data;
      snes_read   = 1'b1;
      snes_write  = 1'b1;
      snes_drv_en = 1'b0;
   endtask

   task automatic avr_access(input logic buffered, input logic is_write, input sram_addr_t a,
                             input byte_t d, output byte_t got, output logic seen);
      seen        = 1'b0;
      avr_ena     = buffered;
      avr_addr    = a;
      avr_in_data = d;
      @(negedge CLK);
      if (is_write) begin
         avr_write = 1'b0;
      end else begin
         avr_read = 1'b0;
      end
      for (int i = 0; i < HOLD_CYC; i++) begin
         @(negedge CLK);
         if (!sram_oe_n || !sram_we_n) begin
            if (!seen) begin
               check("sram_addr", sram_addr, a);
            end
            seen = 1'b1;
         end
      end
      got       = avr_out_data;
      avr_read  = 1'b1;
      avr_write = 1'b1;
   endtask

   // One trace operation and then time for the sequencer to leave HOLD
   task automatic run_op(input logic [15:0] op, input logic [31:0] addr, input byte_t d,
                         input logic md);
      byte_t got;
      logic  seen;
      int    ba;
      mode = md;
      ba   = addr[`SRAM_ADDR_W-1:0];
      case (op)
         "SR": begin
            snes_access(1'b0, addr[23:0], 8'h00, got, seen);
            if (lorom_mapped(addr[23:0])) begin
               expect_ref(lorom_byte(addr[23:0]), d);
               if (!seen) begin
                  report_error("mapped SNES read started no SRAM strobe");
               end
               check("snes_data", got, d);
            end else begin
               check("snes_data", got, 8'hzz);
               check("sram strobe seen", {7'd0, seen}, 8'h00);
            end
         end
         "SW": begin
            snes_access(1'b1, addr[23:0], d, got, seen);
            if (!seen) begin
               report_error("mapped SNES write started no SRAM strobe");
            end
            if (lorom_mapped(addr[23:0])) begin
               ref_mem[lorom_byte(addr[23:0])] = d;
            end
         end
         "DR", "BR": begin
            avr_access(op == "BR", 1'b0, addr[`SRAM_ADDR_W-1:0], 8'h00, got, seen);
            expect_ref(ba, d);
            if (!seen) begin
               report_error("avr read started no SRAM strobe");
            end
            check("avr_out_data", got, d);
         end
         "DW", "BW": begin
            avr_access(op == "BW", 1'b1, addr[`SRAM_ADDR_W-1:0], d, got, seen);
            if (!seen) begin
               report_error("avr write started no SRAM strobe");
            end
            ref_mem[ba] = d;
         end
         default: begin
            report_error("unknown operation in trace");
         end
      endcase
      repeat (4) @(negedge CLK);
      wait_chip_idle();
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      int                fd;
      int                n;
      logic [8*80-1:0]   line;
      logic [15:0]       op;
      logic [31:0]       addr;
      logic [31:0]       data;
      int                md;
      logic [31:0]       ra;
      byte_t             rd;
      CLK          = 1'b0;
      rst_n        = 1'b0;
      snes_addr    = '0;
      snes_read    = 1'b1;
      snes_write   = 1'b1;
      snes_drv     = '0;
      snes_drv_en  = 1'b0;
      avr_addr     = '0;
      avr_read     = 1'b1;
      avr_write    = 1'b1;
      avr_in_data  = '0;
      avr_ena      = 1'b1;
      mode         = 1'b0;
      seed         = 61;
      mismatch_cnt = 0;
      other_cnt    = 0;
      abort        = 1'b0;
      repeat (3) @(negedge CLK);
      rst_n = 1'b1;
      @(negedge CLK);
      // Chip strobes idle before any access
      check("sram_oe_n", {7'd0, sram_oe_n}, 8'h01);
      check("sram_we_n", {7'd0, sram_we_n}, 8'h01);
      fd = $fopen("tb/snes_cart_trace.txt", "r");
      if (fd == 0) begin
         report_error("cannot open the trace file");
         abort = 1'b1;
      end
      while (!abort && !$feof(fd)) begin
         line = '0;
         n    = $fgets(line, fd);
         if (n > 0) begin
            n = $sscanf(line, "%s %h %h %d", op, addr, data, md);
            if (n == 4) begin
               run_op(op, addr, data[7:0], md[0]);
            end
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      // Random direct writes with an immediate read back
      for (int k = 0; k < 8 && !abort; k++) begin
         ra = $random(seed) & ((1 << `SRAM_ADDR_W) - 1);
         rd = $random(seed);
         run_op("DW", ra, rd, 1'b0);
         run_op("DR", ra, ref_mem[int'(ra)], 1'b0);
      end
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_model
   import snes_cart_pkg::*;
(
   input  sram_addr_t      addr,
   input  logic            oe_n,
   input  logic            we_n,
   inout  wire sram_word_t data
);

   localparam int WORD_W = $bits(sram_addr_t) - 1;

   sram_word_t        mem [0:(1 << WORD_W) - 1];
   logic [WORD_W-1:0] word_idx;
   byte_t             hi_in;
   byte_t             lo_in;

   assign word_idx = addr[WORD_W:1];
   assign hi_in    = data[15:8];
   assign lo_in    = data[7:0];

   // Odd byte address sits in the low lane, the other lane floats
   assign data[7:0]  = (!oe_n && we_n && addr[0]) ? mem[word_idx][7:0] : 8'hzz;
   assign data[15:8] = (!oe_n && we_n && !addr[0]) ? mem[word_idx][15:8] : 8'hzz;

   // Level-sensitive write of the addressed lane only
   always @(we_n or word_idx or addr or hi_in or lo_in) begin
      if (!we_n) begin
         if (addr[0] && (^lo_in !== 1'bx)) begin
            mem[word_idx][7:0] = lo_in;
         end
         if (!addr[0] && (^hi_in !== 1'bx)) begin
            mem[word_idx][15:8] = hi_in;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/snes_cart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_cart_top
   import snes_cart_pkg::*;
(
   input  logic            CLK,
   input  logic            rst_n,
   // SNES bus
   input  snes_addr_t      snes_addr,
   input  logic            snes_read,
   input  logic            snes_write,
   inout  wire byte_t      snes_data,
   // avr port
   input  sram_addr_t      avr_addr,
   input  logic            avr_read,
   input  logic            avr_write,
   input  byte_t           avr_in_data,
   output byte_t           avr_out_data,
   input  logic            avr_ena,
   input  logic            mode,
   // SRAM pins
   output sram_addr_t      sram_addr,
   output logic            sram_oe_n,
   output logic            sram_we_n,
   inout  wire sram_word_t sram_data
);

   sram_addr_t snes_sram_addr;
   logic       snes_mapped;
   logic       snes_read_mapped;
   logic       sram_addr0;
   logic       snes_data_to_mem;
   logic       sram_data_to_snes_mem;
   logic       avr_data_to_mem;
   logic       sram_data_to_avr_mem;
   logic       snes_write_gate;

   //////////////////////////////
   // Decode
   //////////////////////////////

   snes_addr_decode u_decode (
      .snes_addr      (snes_addr),
      .snes_sram_addr (snes_sram_addr),
      .snes_mapped    (snes_mapped)
   );

   //////////////////////////////
   // Sequencer
   //////////////////////////////

   sram_sequencer u_seq (
      .CLK                   (CLK),
      .rst_n                 (rst_n),
      .snes_read             (snes_read),
      .snes_write            (snes_write),
      .snes_mapped           (snes_mapped),
      .snes_sram_addr        (snes_sram_addr),
      .avr_read              (avr_read),
      .avr_write             (avr_write),
      .avr_addr              (avr_addr),
      .avr_ena               (avr_ena),
      .sram_addr             (sram_addr),
      .sram_oe_n             (sram_oe_n),
      .sram_we_n             (sram_we_n),
      .sram_addr0            (sram_addr0),
      .snes_data_to_mem      (snes_data_to_mem),
      .sram_data_to_snes_mem (sram_data_to_snes_mem),
      .avr_data_to_mem       (avr_data_to_mem),
      .sram_data_to_avr_mem  (sram_data_to_avr_mem),
      .snes_write_gate       (snes_write_gate)
   );

   //////////////////////////////
   // Data path
   //////////////////////////////

   // Unmapped reads leave the SNES bus floating
   assign snes_read_mapped = snes_read | ~snes_mapped;

   cart_data_path u_data (
      .CLK                   (CLK),
      .snes_read             (snes_read_mapped),
      .snes_write_gate       (snes_write_gate),
      .avr_write             (avr_write),
      .avr_ena               (avr_ena),
      .mode                  (mode),
      .avr_in_data           (avr_in_data),
      .sram_addr0            (sram_addr0),
      .snes_data_to_mem      (snes_data_to_mem),
      .sram_data_to_snes_mem (sram_data_to_snes_mem),
      .avr_data_to_mem       (avr_data_to_mem),
      .sram_data_to_avr_mem  (sram_data_to_avr_mem),
      .avr_out_data          (avr_out_data),
      .snes_data             (snes_data),
      .sram_data             (sram_data)
   );

endmodule

`default_nettype wire

// ==== hw/cart_data_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_data_path
   import snes_cart_pkg::*;
(
   input  logic            CLK,
   input  logic            snes_read,
   input  logic            snes_write_gate,
   input  logic            avr_write,
   input  logic            avr_ena,
   input  logic            mode,
   input  byte_t           avr_in_data,
   input  logic            sram_addr0,
   input  logic            snes_data_to_mem,
   input  logic            sram_data_to_snes_mem,
   input  logic            avr_data_to_mem,
   input  logic            sram_data_to_avr_mem,
   output byte_t           avr_out_data,
   inout  wire byte_t      snes_data,
   inout  wire sram_word_t sram_data
);

   byte_t snes_in_mem;
   byte_t snes_out_mem;
   byte_t avr_in_mem;
   byte_t avr_out_mem;
   byte_t from_sram_byte;
   byte_t wr_byte;
   logic  wr_en;

   //////////////////////////////
   // Read side
   //////////////////////////////

   // Odd address lives in the low lane
   assign from_sram_byte = sram_addr0 ? sram_data[7:0] : sram_data[15:8];

   assign snes_data = snes_read ? 8'hzz : snes_out_mem;

   // Direct mode sees the SRAM byte live
   assign avr_out_data = avr_ena ? avr_out_mem : from_sram_byte;

   //////////////////////////////
   // Write side
   //////////////////////////////

   always_comb begin
      if (!avr_ena) begin
         wr_byte = avr_in_data;
         wr_en   = !avr_write;
      end else if (mode) begin
         wr_byte = avr_in_mem;
         wr_en   = !avr_write;
      end else begin
         wr_byte = snes_in_mem;
         wr_en   = !snes_write_gate;
      end
   end

   // Only the addressed lane is driven
   assign sram_data[7:0]  = (wr_en && sram_addr0) ? wr_byte : 8'hzz;
   assign sram_data[15:8] = (wr_en && !sram_addr0) ? wr_byte : 8'hzz;

   //////////////////////////////
   // Byte buffers
   //////////////////////////////

   always_ff @(posedge CLK) begin
      if (snes_data_to_mem) begin
         snes_in_mem <= snes_data;
      end
      if (avr_data_to_mem) begin
         avr_in_mem <= avr_in_data;
      end
      if (sram_data_to_snes_mem) begin
         snes_out_mem <= from_sram_byte;
      end
      if (sram_data_to_avr_mem) begin
         avr_out_mem <= from_sram_byte;
      end
   end

endmodule

`default_nettype wire

// ==== hw/sram_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snes_cart_settings.svh"

module sram_sequencer
   import snes_cart_pkg::*;
(
   input  logic       CLK,
   input  logic       rst_n,
   input  logic       snes_read,
   input  logic       snes_write,
   input  logic       snes_mapped,
   input  sram_addr_t snes_sram_addr,
   input  logic       avr_read,
   input  logic       avr_write,
   input  sram_addr_t avr_addr,
   input  logic       avr_ena,
   output sram_addr_t sram_addr,
   output logic       sram_oe_n,
   output logic       sram_we_n,
   output logic       sram_addr0,
   output logic       snes_data_to_mem,
   output logic       sram_data_to_snes_mem,
   output logic       avr_data_to_mem,
   output logic       sram_data_to_avr_mem,
   output logic       snes_write_gate
);

   localparam int WAIT_W = $clog2(`SRAM_WAIT + 1);

   // Bit positions in the strobe vector, also the grant priority
   localparam int STB_SRD = 0;
   localparam int STB_SWR = 1;
   localparam int STB_ARD = 2;
   localparam int STB_AWR = 3;

   logic [3:0]        strb;
   logic [3:0]        sync_q1;
   logic [3:0]        sync_q2;
   logic [3:0]        sync_q3;
   logic [3:0]        fall;
   logic [3:0]        req_en;
   logic [3:0]        pend;
   logic [3:0]        req;
   logic [3:0]        grant;
   logic [1:0]        grant_idx;
   logic [1:0]        hold_idx;
   logic              serve_snes;
   logic              last_wait;
   logic [WAIT_W-1:0] wait_cnt;
   seq_state_t        state;
   seq_state_t        state_next;

   //////////////////////////////
   // Strobe sync and edge detect
   //////////////////////////////

   assign strb = {avr_write, avr_read, snes_write, snes_read};

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         sync_q1 <= '1;
         sync_q2 <= '1;
         sync_q3 <= '1;
      end else begin
         sync_q1 <= strb;
         sync_q2 <= sync_q1;
         sync_q3 <= sync_q2;
      end
   end

   assign fall = sync_q3 & ~sync_q2;

   // SNES side only counts in buffered mode and inside the ROM window
   assign req_en = avr_ena ? {2'b11, snes_mapped, snes_mapped} : 4'b0000;

   assign req = (pend | fall) & req_en;

   // A fall not granted right away waits here
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         pend <= '0;
      end else begin
         pend <= req & ~grant;
      end
   end

   //////////////////////////////
   // FSM
   //////////////////////////////

   assign last_wait = (wait_cnt == WAIT_W'(`SRAM_WAIT - 1));

   always_comb begin
      grant      = '0;
      grant_idx  = '0;
      state_next = state;
      case (state)
         IDLE: begin
            // SNES wins when both sides ask together
            if (req[STB_SRD]) begin
               grant[STB_SRD] = 1'b1;
               grant_idx      = 2'(STB_SRD);
               state_next     = SNES_RD;
            end else if (req[STB_SWR]) begin
               grant[STB_SWR] = 1'b1;
               grant_idx      = 2'(STB_SWR);
               state_next     = SNES_WR;
            end else if (req[STB_ARD]) begin
               grant[STB_ARD] = 1'b1;
               grant_idx      = 2'(STB_ARD);
               state_next     = AVR_RD;
            end else if (req[STB_AWR]) begin
               grant[STB_AWR] = 1'b1;
               grant_idx      = 2'(STB_AWR);
               state_next     = AVR_WR;
            end
         end
         SNES_RD, SNES_WR, AVR_RD, AVR_WR: begin
            if (last_wait) begin
               state_next = HOLD;
            end
         end
         HOLD: begin
            // Wait for the served strobe to go high again
            if (sync_q2[hold_idx]) begin
               state_next = IDLE;
            end
         end
         default: begin
            state_next = IDLE;
         end
      endcase
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         state      <= IDLE;
         wait_cnt   <= '0;
         hold_idx   <= '0;
         serve_snes <= 1'b0;
      end else begin
         state <= state_next;
         if (state == IDLE) begin
            wait_cnt   <= '0;
            hold_idx   <= grant_idx;
            serve_snes <= grant[STB_SRD] | grant[STB_SWR];
         end else if (state != HOLD && !last_wait) begin
            wait_cnt <= wait_cnt + 1'b1;
         end
      end
   end

   //////////////////////////////
   // SRAM strobes and capture pulses
   //////////////////////////////

   assign sram_addr  = (avr_ena && serve_snes) ? snes_sram_addr : avr_addr;
   assign sram_addr0 = sram_addr[0];

   // Direct mode hands the chip strobes to the avr
   assign sram_oe_n = avr_ena ? !(state == SNES_RD || state == AVR_RD) : avr_read;
   assign sram_we_n = avr_ena ? !(state == SNES_WR || state == AVR_WR) : avr_write;

   // Write data is latched as the sequence starts
   assign snes_data_to_mem = grant[STB_SWR];
   assign avr_data_to_mem  = grant[STB_AWR];

   // Read data is taken on the last cycle with OE low
   assign sram_data_to_snes_mem = (state == SNES_RD) && last_wait;
   assign sram_data_to_avr_mem  = (state == AVR_RD) && last_wait;

   assign snes_write_gate = (state != SNES_WR);

endmodule

`default_nettype wire

// ==== hw/snes_addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snes_cart_settings.svh"

module snes_addr_decode
   import snes_cart_pkg::*;
(
   input  snes_addr_t snes_addr,
   output sram_addr_t snes_sram_addr,
   output logic       snes_mapped
);

   //////////////////////////////
   // Address fields
   //////////////////////////////

   logic [7:0]                  bank;
   logic [14:0]                 page_offset;
   logic [21:0]                 rom_offset;
   logic [21:0]                 rom_masked;
   logic [`SRAM_ADDR_W-2:0]     word_addr;
   logic                        lane;
   logic                        upper_half;
   logic                        bank_ok;

   assign bank        = snes_addr[23:16];
   assign page_offset = snes_addr[14:0];

   // LoROM only answers in the upper half of each bank
   assign upper_half = snes_addr[15];

   // $7E and $7F belong to WRAM, mirrors start again at $80
   assign bank_ok = (bank < 8'h7E) || (bank >= 8'h80);

   assign snes_mapped = upper_half && bank_ok;

   //////////////////////////////
   // Byte offset into the ROM image
   //////////////////////////////

   // Bank with bit 7 dropped gives the 32K page number
   assign rom_offset = {bank[6:0], page_offset};

   assign rom_masked = rom_offset & `ROM_MASK;

   // Word address on the upper bits, lane select in bit 0
   assign word_addr = rom_masked[`SRAM_ADDR_W-1:1];
   assign lane      = rom_masked[0];

   assign snes_sram_addr = {word_addr, lane};

endmodule

`default_nettype wire

// ==== hw/snes_cart_pkg.sv ====
`default_nettype none

`include "snes_cart_settings.svh"

package snes_cart_pkg;

   //////////////////////////////
   // Data vectors
   //////////////////////////////

   // One byte on either bus
   typedef logic [7:0] byte_t;

   // Full SRAM word, high lane in [15:8]
   typedef logic [15:0] sram_word_t;

   //////////////////////////////
   // Address vectors
   //////////////////////////////

   typedef logic [`SNES_ADDR_W-1:0] snes_addr_t;

   // Byte lane select sits in bit 0
   typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

   //////////////////////////////
   // Sequencer states
   //////////////////////////////

   typedef enum logic [2:0] {
      IDLE,
      SNES_RD,
      SNES_WR,
      AVR_RD,
      AVR_WR,
      HOLD
   } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/snes_cart_settings.svh ====
`ifndef SNES_CART_SETTINGS_SVH
`define SNES_CART_SETTINGS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

// SNES address bus, bank plus 16-bit offset
`define SNES_ADDR_W 24

// SRAM address, bit 0 picks the byte lane
`define SRAM_ADDR_W 19

//////////////////////////////
// SRAM timing
//////////////////////////////

// Cycles a chip strobe stays low per access
`define SRAM_WAIT 3

//////////////////////////////
// ROM window
//////////////////////////////

// Mask on the 22-bit LoROM byte offset, 512 KB window
`define ROM_MASK 22'h07_FFFF

`endif
